//--- hdl/cache_defs.svh
// Cache geometry and widths

`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// data widths
`define CACHE_WORD_W      32
`define CACHE_LINE_W      128

// processor word address split
`define CACHE_ADDR_W      30
`define CACHE_OFFSET_W    2   // word in line
`define CACHE_INDEX_W     2   // set select
`define CACHE_TAG_W       26

// organisation
`define CACHE_WORDS       4
`define CACHE_SETS        4
`define CACHE_WAYS        2

`define CACHE_LINE_ADDR_W 28  // memory is addressed by whole lines

`endif

//--- hdl/cache_pkg.sv
// Cache types
`default_nettype none

`include "cache_defs.svh"

package cache_pkg;

	// ----------------------------------------------------------------------
	// data and address types
	// ----------------------------------------------------------------------
	typedef logic [`CACHE_WORD_W-1:0]      word_t;
	typedef logic [`CACHE_ADDR_W-1:0]      word_addr_t;
	typedef logic [`CACHE_LINE_W-1:0]      line_t;      // word 0 in low bits
	typedef logic [`CACHE_LINE_ADDR_W-1:0] line_addr_t;

	typedef logic [`CACHE_TAG_W-1:0]    tag_t;
	typedef logic [`CACHE_INDEX_W-1:0]  index_t;
	typedef logic [`CACHE_OFFSET_W-1:0] offset_t;
	typedef logic                       way_t;

	// controller states
	typedef enum logic [1:0] {
		CACHE_READY     = 2'd0,
		CACHE_WRITEBACK = 2'd1,
		CACHE_FILL      = 2'd2
	} cache_state_t;

endpackage

`default_nettype wire

//--- hdl/cache_ctrl.sv
// Cache miss controller
`timescale 1ns/1ps
`default_nettype none

`include "cache_defs.svh"

module cache_ctrl import cache_pkg::*; (
	input  wire        clk,
	input  wire        rst_n,
	input  logic       i_proc_read,
	input  logic       i_proc_write,
	input  word_addr_t i_proc_addr,
	input  logic       i_hit,
	input  logic       i_victim_valid,
	input  line_addr_t i_victim_line_addr,
	input  logic       i_mem_ready,
	output logic       o_proc_stall,
	output logic       o_mem_read,
	output logic       o_mem_write,
	output line_addr_t o_mem_addr,
	output logic       o_touch,
	output logic       o_word_write,
	output logic       o_fill_done
);

	cache_state_t state_q;
	cache_state_t state_d;
	logic         req;
	logic         ready_hit;
	line_addr_t   req_line_addr;

	assign req           = i_proc_read | i_proc_write;
	assign ready_hit     = (state_q == CACHE_READY) & i_hit;
	assign req_line_addr = i_proc_addr[`CACHE_ADDR_W-1:`CACHE_OFFSET_W];

	// ----------------------------------------------------------------------
	// processor side
	// ----------------------------------------------------------------------
	assign o_proc_stall = req & ~ready_hit;
	assign o_touch      = req & ready_hit;           // refreshes lru
	assign o_word_write = i_proc_write & ready_hit;

	// ----------------------------------------------------------------------
	// memory side
	// ----------------------------------------------------------------------
	assign o_mem_write = (state_q == CACHE_WRITEBACK);
	assign o_mem_read  = (state_q == CACHE_FILL);
	assign o_fill_done = o_mem_read & i_mem_ready;

	// victim address only while writing back
	assign o_mem_addr = o_mem_write ? i_victim_line_addr : req_line_addr;

	// next state
	always_comb begin
		state_d = state_q;
		case (state_q)
			CACHE_READY: begin
				if (req && !i_hit) begin
					// never loaded ways skip the write-back
					state_d = i_victim_valid ? CACHE_WRITEBACK : CACHE_FILL;
				end
			end
			CACHE_WRITEBACK: begin
				if (i_mem_ready) begin
					state_d = CACHE_FILL;
				end
			end
			CACHE_FILL: begin
				if (i_mem_ready) begin
					state_d = CACHE_READY;
				end
			end
			default: state_d = CACHE_READY;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= CACHE_READY;
		end else begin
			state_q <= state_d;
		end
	end

endmodule

`default_nettype wire

//--- hdl/cache_tag_store.sv
// Tag, valid and LRU store
`timescale 1ns/1ps
`default_nettype none

`include "cache_defs.svh"

module cache_tag_store import cache_pkg::*; (
	input  wire        clk,
	input  wire        rst_n,
	input  word_addr_t i_proc_addr,
	input  logic       i_touch,
	input  logic       i_fill_done,
	output logic       o_hit,
	output way_t       o_sel_way,
	output logic       o_victim_valid,
	output line_addr_t o_victim_line_addr
);

	tag_t tag_q   [`CACHE_SETS][`CACHE_WAYS];
	logic valid_q [`CACHE_SETS][`CACHE_WAYS];
	way_t lru_q   [`CACHE_SETS];   // way to evict next

	index_t                  set_idx;
	tag_t                    req_tag;
	logic [`CACHE_WAYS-1:0]  way_hit;
	way_t                    sel_way;

	assign set_idx = i_proc_addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
	assign req_tag = i_proc_addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];

	// ----------------------------------------------------------------------
	// lookup and way choice
	// ----------------------------------------------------------------------
	always_comb begin
		way_hit = '0;
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			way_hit[w] = valid_q[set_idx][w] && (tag_q[set_idx][w] == req_tag);
		end
	end

	// hit way, else lowest empty way, else lru
	always_comb begin
		sel_way = lru_q[set_idx];
		for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
			if (!valid_q[set_idx][w])
				sel_way = way_t'(w);
		end
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			if (way_hit[w])
				sel_way = way_t'(w);
		end
	end

	assign o_hit              = |way_hit;
	assign o_sel_way          = sel_way;
	assign o_victim_valid     = valid_q[set_idx][sel_way];
	assign o_victim_line_addr = {tag_q[set_idx][sel_way], set_idx};

	// ----------------------------------------------------------------------
	// state update
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int s = 0; s < `CACHE_SETS; s++) begin
				lru_q[s] <= 1'b0;
				for (int w = 0; w < `CACHE_WAYS; w++) begin
					tag_q[s][w]   <= '0;
					valid_q[s][w] <= 1'b0;
				end
			end
		end else if (i_fill_done) begin
			tag_q[set_idx][sel_way]   <= req_tag;
			valid_q[set_idx][sel_way] <= 1'b1;
			lru_q[set_idx]            <= ~sel_way;  // filled way is now newest
		end else if (i_touch) begin
			lru_q[set_idx] <= ~sel_way;
		end
	end

endmodule

`default_nettype wire

//--- hdl/cache_data_store.sv
// Cache line storage
`timescale 1ns/1ps
`default_nettype none

`include "cache_defs.svh"

module cache_data_store import cache_pkg::*; (
	input  wire        clk,
	input  word_addr_t i_proc_addr,
	input  way_t       i_sel_way,
	input  word_t      i_proc_wdata,
	input  logic       i_word_write,
	input  logic       i_fill_done,
	input  line_t      i_mem_rdata,
	output word_t      o_proc_rdata,
	output line_t      o_line
);

	word_t   mem [`CACHE_SETS][`CACHE_WAYS][`CACHE_WORDS];
	index_t  set_idx;
	offset_t word_idx;

	assign word_idx = i_proc_addr[`CACHE_OFFSET_W-1:0];
	assign set_idx  = i_proc_addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];

	// ----------------------------------------------------------------------
	// write port
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (i_fill_done) begin
			for (int w = 0; w < `CACHE_WORDS; w++) begin
				mem[set_idx][i_sel_way][w] <= i_mem_rdata[w*`CACHE_WORD_W +: `CACHE_WORD_W];
			end
		end else if (i_word_write) begin
			mem[set_idx][i_sel_way][word_idx] <= i_proc_wdata;
		end
	end

	// ----------------------------------------------------------------------
	// read ports
	// ----------------------------------------------------------------------
	assign o_proc_rdata = mem[set_idx][i_sel_way][word_idx];

	// whole line for write-back, word 0 lowest
	always_comb begin
		o_line = '0;
		for (int w = 0; w < `CACHE_WORDS; w++) begin
			o_line[w*`CACHE_WORD_W +: `CACHE_WORD_W] = mem[set_idx][i_sel_way][w];
		end
	end

endmodule

`default_nettype wire

//--- hdl/cache_top.sv
// 2-way data cache top
`timescale 1ns/1ps
`default_nettype none

module cache_top import cache_pkg::*; (
	input  wire        clk,
	input  wire        rst_n,
	// processor port
	input  logic       i_proc_read,
	input  logic       i_proc_write,
	input  word_addr_t i_proc_addr,
	input  word_t      i_proc_wdata,
	output word_t      o_proc_rdata,
	output logic       o_proc_stall,
	// memory port
	input  line_t      i_mem_rdata,
	input  logic       i_mem_ready,
	output logic       o_mem_read,
	output logic       o_mem_write,
	output line_addr_t o_mem_addr,
	output line_t      o_mem_wdata
);

	logic       hit;
	logic       victim_valid;
	line_addr_t victim_line_addr;
	way_t       sel_way;
	logic       touch;
	logic       word_write;
	logic       fill_done;

	// ----------------------------------------------------------------------
	// controller
	// ----------------------------------------------------------------------
	cache_ctrl u_ctrl (
		.clk                (clk),
		.rst_n              (rst_n),
		.i_proc_read        (i_proc_read),
		.i_proc_write       (i_proc_write),
		.i_proc_addr        (i_proc_addr),
		.i_hit              (hit),
		.i_victim_valid     (victim_valid),
		.i_victim_line_addr (victim_line_addr),
		.i_mem_ready        (i_mem_ready),
		.o_proc_stall       (o_proc_stall),
		.o_mem_read         (o_mem_read),
		.o_mem_write        (o_mem_write),
		.o_mem_addr         (o_mem_addr),
		.o_touch            (touch),
		.o_word_write       (word_write),
		.o_fill_done        (fill_done)
	);

	// ----------------------------------------------------------------------
	// storage
	// ----------------------------------------------------------------------
	cache_tag_store u_tags (
		.clk                (clk),
		.rst_n              (rst_n),
		.i_proc_addr        (i_proc_addr),
		.i_touch            (touch),
		.i_fill_done        (fill_done),
		.o_hit              (hit),
		.o_sel_way          (sel_way),
		.o_victim_valid     (victim_valid),
		.o_victim_line_addr (victim_line_addr)
	);

	cache_data_store u_data (
		.clk          (clk),
		.i_proc_addr  (i_proc_addr),
		.i_sel_way    (sel_way),
		.i_proc_wdata (i_proc_wdata),
		.i_word_write (word_write),
		.i_fill_done  (fill_done),
		.i_mem_rdata  (i_mem_rdata),
		.o_proc_rdata (o_proc_rdata),
		.o_line       (o_mem_wdata)   // victim line on write-back
	);

endmodule

`default_nettype wire

//--- tb/slow_mem_model.sv
// Slow line memory model
`timescale 1ns/1ps
`default_nettype none

`include "cache_defs.svh"

module slow_mem_model import cache_pkg::*; (
	input  wire        clk,
	input  wire        rst_n,
	input  logic       i_read,
	input  logic       i_write,
	input  line_addr_t i_addr,
	input  line_t      i_wdata,
	output line_t      o_rdata,
	output logic       o_ready
);

	line_t      mem [line_addr_t];   // lines written back so far
	integer     seed = 32'hef5a_ef7b;
	logic       busy;
	logic [2:0] wait_cnt;

	// write-back log, inspected by the testbench
	int         wb_count = 0;
	line_addr_t last_wb_addr;
	line_t      last_wb_line;

	// untouched words hold their own word address, top two bits set
	function automatic line_t read_line(input line_addr_t addr);
		line_t line;
		if (mem.exists(addr))
			return mem[addr];
		for (int w = 0; w < `CACHE_WORDS; w++)
			line[w*`CACHE_WORD_W +: `CACHE_WORD_W] = {2'b11, addr, offset_t'(w)};
		return line;
	endfunction

	// ready for one cycle, 1 to 8 cycles after the strobe is first seen
	always @(negedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_ready  <= 1'b0;
			o_rdata  <= '0;
			busy     <= 1'b0;
			wait_cnt <= '0;
		end else if (o_ready) begin
			o_ready <= 1'b0;
			busy    <= 1'b0;
		end else if (i_read || i_write) begin
			if (!busy) begin
				busy     <= 1'b1;
				wait_cnt <= 3'($random(seed));
			end else if (wait_cnt != 0) begin
				wait_cnt <= wait_cnt - 1'b1;
			end else begin
				o_ready <= 1'b1;
				if (i_write) begin
					mem[i_addr]  = i_wdata;
					wb_count++;
					last_wb_addr = i_addr;
					last_wb_line = i_wdata;
				end else begin
					o_rdata <= read_line(i_addr);
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- tb/tb_cache_top.sv
// Data cache testbench
`timescale 1ns/1ps
`default_nettype none

`include "cache_defs.svh"

module tb_cache_top import cache_pkg::*; ();

	localparam int TIMEOUT_CYCLES = 20000;   // ~315 accesses, ~21 cycle worst miss
	localparam int RANDOM_OPS     = 300;

	logic       clk = 1'b0;
	logic       rst_n;
	logic       proc_read;
	logic       proc_write;
	word_addr_t proc_addr;
	word_t      proc_wdata;
	word_t      proc_rdata;
	logic       proc_stall;
	line_t      mem_rdata;
	logic       mem_ready;
	logic       mem_read;
	logic       mem_write;
	line_addr_t mem_addr;
	line_t      mem_wdata;

	word_t      shadow [word_addr_t];   // words written by the processor
	integer     seed = 32'hef5a_ef7b;
	int         error_count = 0;
	int         check_count = 0;
	int         cycle_count = 0;
	int         held_cycles = 0;
	logic       prev_rd = 1'b0;
	logic       prev_wr = 1'b0;
	line_addr_t prev_addr;
	line_t      prev_wdata;

	always #5 clk = ~clk;

	cache_top u_cache_top (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_proc_read  (proc_read),
		.i_proc_write (proc_write),
		.i_proc_addr  (proc_addr),
		.i_proc_wdata (proc_wdata),
		.o_proc_rdata (proc_rdata),
		.o_proc_stall (proc_stall),
		.i_mem_rdata  (mem_rdata),
		.i_mem_ready  (mem_ready),
		.o_mem_read   (mem_read),
		.o_mem_write  (mem_write),
		.o_mem_addr   (mem_addr),
		.o_mem_wdata  (mem_wdata)
	);

	slow_mem_model u_mem (
		.clk     (clk),
		.rst_n   (rst_n),
		.i_read  (mem_read),
		.i_write (mem_write),
		.i_addr  (mem_addr),
		.i_wdata (mem_wdata),
		.o_rdata (mem_rdata),
		.o_ready (mem_ready)
	);

	// ----------------------------------------------------------------------
	// expected values and compares
	// ----------------------------------------------------------------------
	function automatic word_t expected_word(input word_addr_t addr);
		if (shadow.exists(addr))
			return shadow[addr];
		return {2'b11, addr};
	endfunction

	function automatic word_addr_t build_addr(input tag_t tag, input index_t set, input offset_t off);
		return {tag, set, off};
	endfunction

	task automatic report_error(input string msg);
		$display("ERROR: %s", msg);
		error_count++;
	endtask

	task automatic check_word(input string name, input word_t exp, input word_t act);
		check_count++;
		if (act !== exp) begin
			$display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
			error_count++;
		end
	endtask

	task automatic check_line_addr(input string name, input line_addr_t exp, input line_addr_t act);
		check_count++;
		if (act !== exp) begin
			$display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
			error_count++;
		end
	endtask

	task automatic check_line(input string name, input line_t exp, input line_t act);
		check_count++;
		if (act !== exp) begin
			$display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
			error_count++;
		end
	endtask

	// one processor access, held until stall reads low mid-cycle
	// the request stays up over the next rising edge so a write hit lands
	task automatic cpu_access(input logic wr, input word_addr_t addr, input word_t wdata,
		output word_t rdata, output int stalls);
		@(negedge clk);
		proc_read  = ~wr;
		proc_write = wr;
		proc_addr  = addr;
		proc_wdata = wdata;
		stalls     = 0;
		@(negedge clk);
		while (proc_stall) begin
			stalls++;
			@(negedge clk);
		end
		rdata = proc_rdata;
		if (wr)
			shadow[addr] = wdata;
	endtask

	task automatic checked_read(input string name, input word_addr_t addr, output int stalls);
		word_t rdata;
		cpu_access(1'b0, addr, '0, rdata, stalls);
		check_word(name, expected_word(addr), rdata);
	endtask

	// ----------------------------------------------------------------------
	// directed tests
	// ----------------------------------------------------------------------
	task automatic cold_read_miss();
		int stalls;
		int wb_before;
		wb_before = u_mem.wb_count;
		checked_read("cold_read_miss", build_addr(26'h123, 2'd1, 2'd2), stalls);
		if (stalls == 0)
			report_error("cold_read_miss: the first read did not stall");
		if (u_mem.wb_count != wb_before)
			report_error("cold_read_miss: an invalid way was written back");
	endtask

	task automatic write_hit_readback();
		word_addr_t addr;
		word_t      rdata;
		int         stalls;
		addr = build_addr(26'h123, 2'd1, 2'd0);   // line loaded by the cold read
		cpu_access(1'b1, addr, 32'hcafe_0001, rdata, stalls);
		if (stalls != 0)
			report_error("write_hit_readback: the write hit stalled");
		checked_read("write_hit_readback", addr, stalls);
		if (stalls != 0)
			report_error("write_hit_readback: the read hit stalled");
	endtask

	task automatic lru_eviction();
		word_addr_t a;
		word_addr_t b;
		int         stalls;
		int         wb_before;
		a = build_addr(26'h10, 2'd2, 2'd0);
		b = build_addr(26'h20, 2'd2, 2'd1);
		checked_read("lru_eviction", a, stalls);
		checked_read("lru_eviction", b, stalls);
		checked_read("lru_eviction", a, stalls);   // b is now oldest
		wb_before = u_mem.wb_count;
		checked_read("lru_eviction", build_addr(26'h30, 2'd2, 2'd3), stalls);
		if (u_mem.wb_count != wb_before + 1)
			report_error("lru_eviction: the miss did not write back one line");
		check_line_addr("lru_eviction", b[`CACHE_ADDR_W-1:`CACHE_OFFSET_W], u_mem.last_wb_addr);
		checked_read("lru_eviction", a, stalls);
		if (stalls != 0)
			report_error("lru_eviction: the recently used line was evicted");
	endtask

	task automatic writeback_data();
		word_addr_t d;
		line_addr_t d_line;
		line_t      exp_line;
		word_t      rdata;
		int         stalls;
		d      = build_addr(26'h40, 2'd3, 2'd1);
		d_line = d[`CACHE_ADDR_W-1:`CACHE_OFFSET_W];
		checked_read("writeback_data", d, stalls);
		cpu_access(1'b1, d, 32'h5a5a_1234, rdata, stalls);
		checked_read("writeback_data", build_addr(26'h50, 2'd3, 2'd0), stalls);
		checked_read("writeback_data", build_addr(26'h60, 2'd3, 2'd2), stalls);
		for (int w = 0; w < `CACHE_WORDS; w++)
			exp_line[w*`CACHE_WORD_W +: `CACHE_WORD_W] = expected_word({d_line, offset_t'(w)});
		check_line_addr("writeback_data", d_line, u_mem.last_wb_addr);
		check_line("writeback_data", exp_line, u_mem.last_wb_line);
	endtask

	// 16 addresses, four tags in each set
	task automatic random_mix();
		logic [3:0] idx;
		word_addr_t addr;
		word_t      rdata;
		int         stalls;
		for (int i = 0; i < RANDOM_OPS; i++) begin
			idx  = 4'($random(seed));
			addr = build_addr(tag_t'(26'h100 + idx[3:2]), idx[1:0], idx[3:2]);
			if ($random(seed) & 1)
				cpu_access(1'b1, addr, word_t'($random(seed)), rdata, stalls);
			else
				checked_read("random_mix", addr, stalls);
		end
	endtask

	task automatic backpressure_seen();
		if (held_cycles == 0)
			report_error("backpressure_seen: memory never held ready low during a miss");
	endtask

	// ----------------------------------------------------------------------
	// monitors
	// ----------------------------------------------------------------------
	// mem_ready read here is the value seen at the last rising edge
	always @(negedge clk) begin
		if (!rst_n) begin
			prev_rd = 1'b0;
			prev_wr = 1'b0;
		end else begin
			if ((prev_rd || prev_wr) && !mem_ready) begin
				held_cycles++;
				if (mem_read !== prev_rd || mem_write !== prev_wr)
					report_error("back_pressure: memory strobe changed while ready was low");
				check_line_addr("back_pressure", prev_addr, mem_addr);
				check_line("back_pressure", prev_wdata, mem_wdata);
			end
			prev_rd    = mem_read;
			prev_wr    = mem_write;
			prev_addr  = mem_addr;
			prev_wdata = mem_wdata;
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: the run hung after %0d cycles", cycle_count);
			$display("checks: %0d, errors: %0d", check_count, error_count);
			$display("Regression failed");
			$finish;
		end
	end

	initial begin
		rst_n      = 1'b0;
		proc_read  = 1'b0;
		proc_write = 1'b0;
		proc_addr  = '0;
		proc_wdata = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		cold_read_miss();
		write_hit_readback();
		lru_eviction();
		writeback_data();
		random_mix();
		backpressure_seen();

		@(negedge clk);
		proc_read  = 1'b0;
		proc_write = 1'b0;
		$display("checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
+incdir+hdl
hdl/cache_pkg.sv
hdl/cache_ctrl.sv
hdl/cache_tag_store.sv
hdl/cache_data_store.sv
hdl/cache_top.sv
tb/slow_mem_model.sv
tb/tb_cache_top.sv
